//--- design/snes_mem_consts.svh
`ifndef SNES_MEM_CONSTS_SVH
`define SNES_MEM_CONSTS_SVH

// Memory word and store geometry
`define MEM_DATA_W   16
`define MEM_ADDR_W   12    // Top bit picks the region, 0 is ROM and 1 is work RAM

// Byte address widths on the CPU side
`define ROM_ADDR_W   12
`define WRAM_ADDR_W  12

// Cycles the word store spends on one access
`define MEM_LATENCY  4

`endif

//--- design/mem_types_pkg.sv
`include "snes_mem_consts.svh"

package mem_types_pkg;

    // One memory word, read whole or as two bytes
    typedef union packed {
        logic [`MEM_DATA_W-1:0] word;
        struct packed {
            logic [`MEM_DATA_W/2-1:0] hi;   // Odd byte address
            logic [`MEM_DATA_W/2-1:0] lo;   // Even byte address
        } bytes;
    } mem_word_u;

    // Write enable per byte lane, bit 1 is the high byte
    typedef logic [1:0] lane_mask_t;

    // Which requester a read result belongs to
    typedef enum logic {
        port_rom  = 1'b0,
        port_wram = 1'b1
    } port_t;

    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

endpackage

//--- design/bus_pkg.sv
`include "snes_mem_consts.svh"

package bus_pkg;

    // Data byte on the CPU side buses
    typedef logic [7:0] bus_byte_t;

    // Cartridge ROM byte address
    typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;

    // Work RAM byte address
    typedef logic [`WRAM_ADDR_W-1:0] wram_addr_t;

endpackage

//--- design/mem_req_if.sv
`timescale 1ns/10ps

// Toggle request channel into the memory engine
interface mem_req_if
    import mem_types_pkg::*;
();
    logic       req;     // Flipped by the issuer to start an access
    logic       ack;     // Flipped by the server when the access is done
    mem_addr_t  addr;
    logic       we;
    lane_mask_t lanes;
    mem_word_u  wdata;
    port_t      port;

    // Payload stays put from the req flip until ack catches up
    modport issuer (
        output req, addr, we, lanes, wdata, port,
        input  ack
    );

    modport server (
        input  req, addr, we, lanes, wdata, port,
        output ack
    );

endinterface

//--- design/rom_loader.sv
`timescale 1ns/10ps

module rom_loader
    import bus_pkg::*;
(
    input  logic      mclk,
    input  logic      resetn,
    input  logic      loading,
    input  logic      loader_valid,
    input  bus_byte_t loader_data,
    output rom_addr_t load_addr,
    output bus_byte_t prev_byte,
    output logic      load_strobe,
    output logic      loaded
);
    logic loading_r;
    logic byte_in;

    assign byte_in = loading && loader_valid;

    // Odd address completes a byte pair
    assign load_strobe = byte_in && load_addr[0];

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r <= 1'b0;
            loaded    <= 1'b0;
            load_addr <= '0;
        end else begin
            loading_r <= loading;
            if (byte_in)
                load_addr <= load_addr + rom_addr_t'(1);
            // New load window starts from address zero
            if (loading && !loading_r) begin
                load_addr <= '0;
                loaded    <= 1'b0;
            end
            if (!loading && loading_r)
                loaded <= 1'b1;     // Window closed
        end
    end

    // Even byte waits here for its partner
    always_ff @(posedge mclk) begin
        if (byte_in)
            prev_byte <= loader_data;
    end

endmodule

//--- design/access_decode.sv
`timescale 1ns/10ps
`include "snes_mem_consts.svh"

module access_decode
    import mem_types_pkg::*, bus_pkg::*;
(
    input  logic       mclk,
    input  logic       resetn,
    input  logic       loading,
    input  rom_addr_t  load_addr,
    input  bus_byte_t  prev_byte,
    input  bus_byte_t  loader_data,
    input  logic       load_strobe,
    input  rom_addr_t  rom_addr,
    input  logic       rom_ce_n,
    input  wram_addr_t wram_addr,
    input  logic       wram_ce_n,
    input  logic       wram_rd_n,
    input  logic       wram_we_n,
    input  bus_byte_t  wram_d,
    mem_req_if.issuer  chan,
    output logic       mem_busy
);
    logic                    wram_rd;
    logic                    wram_wr;
    logic                    wram_rd_r;
    logic                    wram_wr_r;
    logic                    rom_hit;
    logic                    wram_hit;
    logic [`ROM_ADDR_W-2:0]  rom_last;       // Word of the last ROM read
    logic                    rom_last_vld;
    logic [`WRAM_ADDR_W-2:0] wram_last;

    // ROM slot
    logic       rom_pend;
    logic       rom_we_q;
    mem_addr_t  rom_addr_q;
    mem_word_u  rom_wdata_q;

    // Work RAM slot
    logic       wram_pend;
    logic       wram_we_q;
    mem_addr_t  wram_addr_q;
    lane_mask_t wram_lanes_q;
    mem_word_u  wram_wdata_q;

    logic chan_free;
    logic issue;
    logic pick_wram;

    assign wram_rd = !wram_ce_n && !wram_rd_n;
    assign wram_wr = !wram_ce_n && !wram_we_n;

    assign rom_hit = !loading && !rom_ce_n &&
                     (!rom_last_vld || rom_addr[`ROM_ADDR_W-1:1] != rom_last);
    assign wram_hit = (wram_rd && !wram_rd_r) || (wram_wr && !wram_wr_r) ||
                      (wram_rd && wram_addr[`WRAM_ADDR_W-1:1] != wram_last);

    assign chan_free = (chan.req == chan.ack);
    assign pick_wram = wram_pend;               // Work RAM wins a tie
    assign issue     = chan_free && (rom_pend || wram_pend);
    assign mem_busy  = rom_pend || wram_pend || !chan_free;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            wram_rd_r    <= 1'b0;
            wram_wr_r    <= 1'b0;
            rom_pend     <= 1'b0;
            wram_pend    <= 1'b0;
            rom_last_vld <= 1'b0;
            wram_last    <= '0;
            chan.req     <= 1'b0;
        end else begin
            wram_rd_r <= wram_rd;
            wram_wr_r <= wram_wr;
            if (issue) begin
                chan.req <= ~chan.req;
                if (pick_wram)
                    wram_pend <= 1'b0;
                else
                    rom_pend <= 1'b0;
            end
            // A fill in the same cycle keeps the slot pending
            if (load_strobe) begin
                rom_pend     <= 1'b1;
                rom_last_vld <= 1'b0;   // Next read must go to memory
            end else if (rom_hit) begin
                rom_pend     <= 1'b1;
                rom_last_vld <= 1'b1;
            end
            if (wram_hit) begin
                wram_pend <= 1'b1;
                wram_last <= wram_addr[`WRAM_ADDR_W-1:1];
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (load_strobe) begin
            rom_addr_q            <= {1'b0, load_addr[`ROM_ADDR_W-1:1]};
            rom_we_q              <= 1'b1;
            rom_wdata_q.bytes.hi  <= loader_data;   // Odd byte
            rom_wdata_q.bytes.lo  <= prev_byte;
        end else if (rom_hit) begin
            rom_addr_q <= {1'b0, rom_addr[`ROM_ADDR_W-1:1]};
            rom_we_q   <= 1'b0;
            rom_last   <= rom_addr[`ROM_ADDR_W-1:1];
        end
        if (wram_hit) begin
            wram_addr_q           <= {1'b1, wram_addr[`WRAM_ADDR_W-1:1]};
            wram_we_q             <= wram_wr;
            wram_lanes_q          <= wram_wr ? {wram_addr[0], !wram_addr[0]} : 2'b11;
            wram_wdata_q.bytes.hi <= wram_d;        // Same byte on both lanes
            wram_wdata_q.bytes.lo <= wram_d;
        end
        // Channel payload
        if (issue) begin
            chan.addr  <= pick_wram ? wram_addr_q : rom_addr_q;
            chan.we    <= pick_wram ? wram_we_q : rom_we_q;
            chan.lanes <= pick_wram ? wram_lanes_q : 2'b11;
            chan.wdata <= pick_wram ? wram_wdata_q : rom_wdata_q;
            chan.port  <= pick_wram ? port_wram : port_rom;
        end
    end

    // Loader pairs must be spaced wider than one access
    a_load_no_overrun : assert property (
        @(posedge mclk) disable iff (!resetn)
        load_strobe |-> !(rom_pend && rom_we_q)
    ) else $error("loader word overwritten while still pending");

endmodule

//--- design/mem_execute.sv
`timescale 1ns/10ps
`include "snes_mem_consts.svh"

module mem_execute
    import mem_types_pkg::*;
(
    input  logic      mclk,
    input  logic      resetn,
    mem_req_if.server chan,
    output logic      rd_valid,
    output port_t     rd_port,
    output mem_word_u rd_data
);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    mem_word_u        store [0:(1 << `MEM_ADDR_W) - 1];
    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             start;
    logic             done;
    mem_addr_t        addr_q;
    logic             we_q;
    lane_mask_t       lanes_q;
    mem_word_u        wdata_q;

    assign start    = !busy && (chan.req != chan.ack);
    assign done     = busy && (cnt == '0);
    assign rd_valid = done && !we_q;        // Reads only

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            cnt      <= '0;
            chan.ack <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(`MEM_LATENCY - 1);
        end else if (done) begin
            busy     <= 1'b0;
            chan.ack <= ~chan.ack;          // Completes the handshake
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Request latch
    always_ff @(posedge mclk) begin
        if (start) begin
            addr_q  <= chan.addr;
            we_q    <= chan.we;
            lanes_q <= chan.lanes;
            wdata_q <= chan.wdata;
            rd_port <= chan.port;
        end
    end

    // Read word settles one cycle after addr_q, so latency must be 2 or more
    always_ff @(posedge mclk) begin
        rd_data <= store[addr_q];
        if (done && we_q) begin
            if (lanes_q[0])
                store[addr_q].bytes.lo <= wdata_q.bytes.lo;
            if (lanes_q[1])
                store[addr_q].bytes.hi <= wdata_q.bytes.hi;
        end
    end

    // The issuer must wait for ack before a new flip
    a_req_held : assert property (
        @(posedge mclk) disable iff (!resetn)
        busy |-> $stable(chan.req)
    ) else $error("req changed during an access");

endmodule

//--- design/read_result.sv
`timescale 1ns/10ps
`include "snes_mem_consts.svh"

module read_result
    import mem_types_pkg::*, bus_pkg::*;
(
    input  logic                   mclk,
    input  logic                   resetn,
    input  logic                   rd_valid,
    input  port_t                  rd_port,
    input  mem_word_u              rd_data,
    input  rom_addr_t              rom_addr,
    input  logic                   rom_word,
    input  wram_addr_t             wram_addr,
    output logic [`MEM_DATA_W-1:0] rom_q,
    output bus_byte_t              wram_q
);
    mem_word_u rom_res;
    mem_word_u wram_res;

    // Last word returned to each port
    always_ff @(posedge mclk) begin
        if (!resetn) begin
            rom_res  <= '0;
            wram_res <= '0;
        end else if (rd_valid) begin
            if (rd_port == port_wram)
                wram_res <= rd_data;
            else
                rom_res <= rd_data;
        end
    end

    // Odd byte access sees the pair swapped
    assign rom_q = (rom_word || !rom_addr[0]) ? rom_res.word
                                              : {rom_res.bytes.lo, rom_res.bytes.hi};

    assign wram_q = wram_addr[0] ? wram_res.bytes.hi : wram_res.bytes.lo;

endmodule

//--- design/snes_mem_top.sv
`timescale 1ns/10ps
`include "snes_mem_consts.svh"

module snes_mem_top
    import mem_types_pkg::*, bus_pkg::*;
(
    input  logic                   mclk,
    input  logic                   resetn,
    input  logic                   loading,
    input  logic                   loader_valid,
    input  bus_byte_t              loader_data,
    output logic                   loaded,
    input  rom_addr_t              rom_addr,
    input  logic                   rom_ce_n,
    input  logic                   rom_word,
    output logic [`MEM_DATA_W-1:0] rom_q,
    input  wram_addr_t             wram_addr,
    input  logic                   wram_ce_n,
    input  logic                   wram_rd_n,
    input  logic                   wram_we_n,
    input  bus_byte_t              wram_d,
    output bus_byte_t              wram_q,
    output logic                   mem_busy
);
    rom_addr_t load_addr;
    bus_byte_t prev_byte;
    logic      load_strobe;
    logic      rd_valid;
    port_t     rd_port;
    mem_word_u rd_data;

    mem_req_if chan ();

    rom_loader u_loader (
        .mclk(mclk), .resetn(resetn),
        .loading(loading), .loader_valid(loader_valid), .loader_data(loader_data),
        .load_addr(load_addr), .prev_byte(prev_byte),
        .load_strobe(load_strobe), .loaded(loaded)
    );

    access_decode u_decode (
        .mclk(mclk), .resetn(resetn), .loading(loading),
        .load_addr(load_addr), .prev_byte(prev_byte),
        .loader_data(loader_data), .load_strobe(load_strobe),
        .rom_addr(rom_addr), .rom_ce_n(rom_ce_n),
        .wram_addr(wram_addr), .wram_ce_n(wram_ce_n),
        .wram_rd_n(wram_rd_n), .wram_we_n(wram_we_n), .wram_d(wram_d),
        .chan(chan.issuer), .mem_busy(mem_busy)
    );

    mem_execute u_execute (
        .mclk(mclk), .resetn(resetn), .chan(chan.server),
        .rd_valid(rd_valid), .rd_port(rd_port), .rd_data(rd_data)
    );

    read_result u_result (
        .mclk(mclk), .resetn(resetn),
        .rd_valid(rd_valid), .rd_port(rd_port), .rd_data(rd_data),
        .rom_addr(rom_addr), .rom_word(rom_word), .wram_addr(wram_addr),
        .rom_q(rom_q), .wram_q(wram_q)
    );

endmodule

//--- testbench/tb_snes_mem.sv
`timescale 1ns/10ps
`include "snes_mem_consts.svh"

module tb_snes_mem
    import bus_pkg::*;
();
    localparam int LOAD_BYTES  = 64;
    localparam int WRAM_WORDS  = 4;
    localparam int STEP_CYCLES = 2 * `MEM_LATENCY + 10;
    localparam int STEPS       = LOAD_BYTES + 3 * (LOAD_BYTES / 2) + 4 * WRAM_WORDS + 20;
    localparam int IDLE_LIMIT  = 4 * `MEM_LATENCY + 10;   // Per access, in cycles

    logic                   mclk;
    logic                   resetn;
    logic                   loading;
    logic                   loader_valid;
    bus_byte_t              loader_data;
    logic                   loaded;
    rom_addr_t              rom_addr;
    logic                   rom_ce_n;
    logic                   rom_word;
    logic [`MEM_DATA_W-1:0] rom_q;
    wram_addr_t             wram_addr;
    logic                   wram_ce_n;
    logic                   wram_rd_n;
    logic                   wram_we_n;
    bus_byte_t              wram_d;
    bus_byte_t              wram_q;
    logic                   mem_busy;

    bus_byte_t rom_model  [0:LOAD_BYTES-1];
    bus_byte_t wram_model [0:(1 << `WRAM_ADDR_W) - 1];
    integer    seed = 32'hf2ca_3ba1;
    int        errors = 0;
    int        tests_run = 0;
    int        tests_bad = 0;

    snes_mem_top dut (
        .mclk(mclk), .resetn(resetn),
        .loading(loading), .loader_valid(loader_valid), .loader_data(loader_data),
        .loaded(loaded),
        .rom_addr(rom_addr), .rom_ce_n(rom_ce_n), .rom_word(rom_word), .rom_q(rom_q),
        .wram_addr(wram_addr), .wram_ce_n(wram_ce_n), .wram_rd_n(wram_rd_n),
        .wram_we_n(wram_we_n), .wram_d(wram_d), .wram_q(wram_q),
        .mem_busy(mem_busy)
    );

    always #50 mclk = ~mclk;    // 100 ns period

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] act);
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
        errors++;
    endtask

    // Called on a falling edge, returns on the first falling edge with mem_busy low
    task automatic wait_idle();
        int n;
        n = 0;
        while (mem_busy && n < IDLE_LIMIT) begin
            @(negedge mclk);
            n++;
        end
        if (mem_busy) begin
            $display("mem_busy stayed high for %0d cycles at t=%0t", IDLE_LIMIT, $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before)
            tests_bad++;
        $display("%s done, %0d errors", name, errors - errs_before);
    endtask

    task automatic read_rom(input rom_addr_t a, input logic whole, output logic [15:0] q);
        @(negedge mclk);
        rom_addr = a;
        rom_word = whole;
        rom_ce_n = 1'b0;
        @(negedge mclk);            // Access is picked up on the edge in between
        wait_idle();
        q = rom_q;
        rom_ce_n = 1'b1;
    endtask

    task automatic write_wram(input wram_addr_t a, input bus_byte_t d);
        @(negedge mclk);
        wram_addr = a;
        wram_d    = d;
        wram_ce_n = 1'b0;
        wram_we_n = 1'b0;
        @(negedge mclk);
        wram_ce_n = 1'b1;
        wram_we_n = 1'b1;
        wait_idle();
        wram_model[a] = d;
    endtask

    task automatic read_wram(input wram_addr_t a, output bus_byte_t q);
        @(negedge mclk);
        wram_addr = a;
        wram_ce_n = 1'b0;
        wram_rd_n = 1'b0;
        @(negedge mclk);
        wait_idle();
        q = wram_q;
        wram_ce_n = 1'b1;
        wram_rd_n = 1'b1;
    endtask

    task automatic check_reset_state();
        int e0;
        e0 = errors;
        if (loaded !== 1'b0)
            report_mismatch("loaded", 16'h0, {15'h0, loaded});
        if (mem_busy !== 1'b0)
            report_mismatch("mem_busy", 16'h0, {15'h0, mem_busy});
        if (rom_q !== 16'h0)
            report_mismatch("rom_q", 16'h0, rom_q);
        if (wram_q !== 8'h0)
            report_mismatch("wram_q", 16'h0, {8'h0, wram_q});
        finish_test("reset_state", e0);
    endtask

    task automatic load_cartridge();
        int          e0;
        logic [15:0] got;
        e0 = errors;
        @(negedge mclk);
        loading = 1'b1;
        repeat (3) @(negedge mclk);
        for (int i = 0; i < LOAD_BYTES; i++) begin
            rom_model[i] = $random(seed);
            loader_data  = rom_model[i];
            loader_valid = 1'b1;
            @(negedge mclk);
            loader_valid = 1'b0;
            repeat (11) @(negedge mclk);    // 12 cycles between bytes
        end
        loading = 1'b0;
        @(negedge mclk);
        wait_idle();
        repeat (2) @(negedge mclk);
        if (loaded !== 1'b1)
            report_mismatch("loaded", 16'h1, {15'h0, loaded});
        for (int k = 0; k < LOAD_BYTES; k += 2) begin
            read_rom(rom_addr_t'(k), 1'b1, got);
            if (got !== {rom_model[k+1], rom_model[k]})
                report_mismatch("rom_q", {rom_model[k+1], rom_model[k]}, got);
        end
        finish_test("cart_load", e0);
    endtask

    task automatic read_odd_rom();
        int          e0;
        logic [15:0] got;
        e0 = errors;
        for (int k = 0; k < LOAD_BYTES; k += 2) begin
            read_rom(rom_addr_t'(k + 1), 1'b0, got);
            if (got !== {rom_model[k], rom_model[k+1]})
                report_mismatch("rom_q", {rom_model[k], rom_model[k+1]}, got);
            // Word access at the same odd address keeps the stored order
            read_rom(rom_addr_t'(k + 1), 1'b1, got);
            if (got !== {rom_model[k+1], rom_model[k]})
                report_mismatch("rom_q", {rom_model[k+1], rom_model[k]}, got);
        end
        finish_test("odd_rom", e0);
    endtask

    task automatic exercise_wram_bytes();
        int         e0;
        wram_addr_t a;
        bus_byte_t  lo;
        bus_byte_t  got;
        e0 = errors;
        for (int i = 0; i < WRAM_WORDS; i++) begin
            a  = wram_addr_t'(12'h200 + 2 * i);
            lo = $random(seed);
            write_wram(a, lo);
            write_wram(a + 1'b1, lo ^ 8'h5a);   // Neighbour byte differs
        end
        for (int i = 0; i < 2 * WRAM_WORDS; i++) begin
            a = wram_addr_t'(12'h200 + i);
            read_wram(a, got);
            if (got !== wram_model[a])
                report_mismatch("wram_q", {8'h0, wram_model[a]}, {8'h0, got});
        end
        finish_test("wram_bytes", e0);
    endtask

    task automatic run_contention();
        int        e0;
        bus_byte_t got;
        e0 = errors;
        @(negedge mclk);
        rom_addr  = 12'd10;         // Word not read last
        rom_word  = 1'b1;
        rom_ce_n  = 1'b0;
        wram_addr = 12'h300;
        wram_d    = 8'hc3;
        wram_ce_n = 1'b0;
        wram_we_n = 1'b0;
        @(negedge mclk);
        wram_ce_n = 1'b1;
        wram_we_n = 1'b1;
        wait_idle();
        if (rom_q !== {rom_model[11], rom_model[10]})
            report_mismatch("rom_q", {rom_model[11], rom_model[10]}, rom_q);
        rom_ce_n = 1'b1;
        wram_model[12'h300] = 8'hc3;
        read_wram(12'h300, got);
        if (got !== wram_model[12'h300])
            report_mismatch("wram_q", {8'h0, wram_model[12'h300]}, {8'h0, got});
        finish_test("contention", e0);
    endtask

    // Watchdog sized from the step count
    initial begin
        repeat (STEPS * STEP_CYCLES + 500) @(posedge mclk);
        $display("Run did not finish within the expected number of cycles");
        $display("tests failed");
        $finish;
    end

    initial begin
        mclk         = 1'b0;
        resetn       = 1'b0;
        loading      = 1'b0;
        loader_valid = 1'b0;
        loader_data  = '0;
        rom_addr     = '0;
        rom_ce_n     = 1'b1;
        rom_word     = 1'b0;
        wram_addr    = '0;
        wram_ce_n    = 1'b1;
        wram_rd_n    = 1'b1;
        wram_we_n    = 1'b1;
        wram_d       = '0;
        repeat (5) @(negedge mclk);
        resetn = 1'b1;
        @(negedge mclk);

        check_reset_state();
        load_cartridge();
        read_odd_rom();
        exercise_wram_bytes();
        run_contention();

        $display("summary: %0d run, %0d with errors, %0d check errors",
                 tests_run, tests_bad, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- snes_mem.f
+incdir+design
design/mem_types_pkg.sv
design/bus_pkg.sv
design/mem_req_if.sv
design/rom_loader.sv
design/access_decode.sv
design/mem_execute.sv
design/read_result.sv
design/snes_mem_top.sv
testbench/tb_snes_mem.sv

//--- Bender.yml
package:
  name: snes_mem

sources:
  - include_dirs:
      - design
    files:
      - design/mem_types_pkg.sv
      - design/bus_pkg.sv
      - design/mem_req_if.sv
      - design/rom_loader.sv
      - design/access_decode.sv
      - design/mem_execute.sv
      - design/read_result.sv
      - design/snes_mem_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_snes_mem.sv
